// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0 --Mdir obj_dir
TOP       = vdma_ctrl_tb
FILELIST  = vdma_ctrl.f
LOG       = sim.log
FAIL_MSG  = Something failed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@./obj_dir/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation FAILED"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

// File: vdma_ctrl.f
verilog/vdma_pkg.sv
verilog/vdma_buf_if.sv
verilog/vdma_frame_done.sv
verilog/vdma_flip_ctrl.sv
verilog/vdma_regs.sv
verilog/vdma_ctrl_top.sv
verification/vdma_ctrl_tb.sv

// File: verification/vdma_ctrl_patterns.txt
# op W addr data rnd | op R addr expect rnd (rnd 1 uses LCG data) | op F chan(0 wr, 1 rd) ctl
# op S startmask(1 wr, 2 rd) new write read wr_addr_o rd_addr_o, all fields hex
R 00 56444d41 0
R 01 00010000 0
R 04 00000003 0
R 08 00000000 0
R 09 00100000 0
R 0a 00200000 0
R 0c 00000003 0
R 0d 00000003 0
R 0e 00000003 0
W 08 00000000 1
R 08 00000000 1
W 48 00000000 1
R 48 00000000 1
R 30 00000000 0
W 08 10000000 0
W 09 10400003 0
R 09 10400000 0
W 0a 10800000 0
W 48 20000000 0
S 1 3 0 3 10000000 00000000
S 1 0 1 3 10400000 00000000
S 2 0 1 0 10400000 10000000
S 1 1 2 0 10800000 10000000
S 2 1 2 1 10800000 10400000
S 1 2 0 1 10000000 10400000
S 3 0 1 0 10400000 10000000
W 04 00000002 0
S 1 1 2 0 20000000 10000000
W 44 00000007 0
F 0 00000000
W 44 00000003 0
F 0 00000001
W 84 00000003 0
F 1 00000003
W 84 00000006 0
F 1 00000002
W 04 00000000 0
W 84 00000007 0
F 1 00000000

// File: verification/vdma_ctrl_tb.sv
/* testbench for the video DMA control block
   pattern-driven bus and engine stimulus, buffer rotation reference model */
`timescale 1ns/1ps

module vdma_ctrl_tb
	import vdma_pkg::*;
	();

	localparam string pattern_file = "verification/vdma_ctrl_patterns.txt";

	logic                m_axi4_aclk;
	logic                s_wb_rst_i;
	logic [wb_adr_w-1:0] s_wb_adr_i;
	logic [wb_dat_w-1:0] s_wb_dat_i;
	logic                s_wb_we_i;
	logic [wb_sel_w-1:0] s_wb_sel_i;
	logic                s_wb_stb_i;
	logic [wb_dat_w-1:0] s_wb_dat_o;
	logic                s_wb_ack_o;
	logic                wr_irq_o;
	logic                rd_irq_o;
	logic                wr_enable_o;
	logic                wr_update_o;
	logic [addr_w-1:0]   wr_addr_o;
	logic                wr_start_i;
	logic                wr_busy_i;
	logic [index_w-1:0]  wr_index_i;
	logic                rd_enable_o;
	logic                rd_update_o;
	logic [addr_w-1:0]   rd_addr_o;
	logic                rd_start_i;
	logic                rd_busy_i;
	logic [index_w-1:0]  rd_index_i;

	// reference model state
	logic [addr_w-1:0] model_base [0:2];
	logic [addr_w-1:0] model_wr_manual;
	logic [addr_w-1:0] model_rd_manual;
	logic [1:0]        model_autoflip;
	logic [buf_w-1:0]  model_new;
	logic [buf_w-1:0]  model_write;
	logic [buf_w-1:0]  model_read;

	logic [31:0] lcg_state;
	logic [31:0] last_rand;
	int          err_cnt = 0;
	int          check_cnt = 0;
	int          cycle_cnt = 0;
	int          cycle_limit = 100;

	vdma_ctrl_top i_vdma_ctrl_top (.*);

	initial begin
		m_axi4_aclk = 1'b0;
		forever #2 m_axi4_aclk = ~m_axi4_aclk;
	end

	always @(posedge m_axi4_aclk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt > cycle_limit) begin
			$display("timeout after %0d cycles, %0d errors so far", cycle_cnt, err_cnt);
			$display("Something failed");
			$finish;
		end
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] cur);
		return cur * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic logic [addr_w-1:0] model_addr(input logic flip_en,
		input logic [buf_w-1:0] sel, input logic [addr_w-1:0] manual);
		if (flip_en && sel != buf_none) begin
			return model_base[sel];
		end
		return manual;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		check_cnt++;
		assert (got === exp) else begin
			err_cnt++;
			$display("Fail at %0t: %s expected %h got %h", $time, name, exp, got);
		end
	endtask

	task automatic check_pattern(input string name, input logic [31:0] file_val,
		input logic [31:0] model_val);
		assert (file_val === model_val) else begin
			err_cnt++;
			$display("pattern file gives %h for %s, the reference model expects %h",
				file_val, name, model_val);
		end
	endtask

	task automatic check_fields(input int got, input int want, input logic [7:0] op);
		assert (got == want) else begin
			err_cnt++;
			$display("pattern line %c holds %0d fields instead of %0d", op, got, want);
		end
	endtask

	// ------------------------------
	// wishbone master
	// ------------------------------
	task automatic bus_write(input logic [wb_adr_w-1:0] adr, input logic [wb_dat_w-1:0] data);
		@(posedge m_axi4_aclk);
		s_wb_adr_i <= adr;
		s_wb_dat_i <= data;
		s_wb_we_i  <= 1'b1;
		s_wb_sel_i <= '1;
		s_wb_stb_i <= 1'b1;
		@(negedge m_axi4_aclk);
		check_value("s_wb_ack_o", {31'b0, s_wb_ack_o}, 32'd1);
		@(posedge m_axi4_aclk);
		s_wb_we_i  <= 1'b0;
		s_wb_stb_i <= 1'b0;
	endtask

	task automatic bus_read(input logic [wb_adr_w-1:0] adr, output logic [wb_dat_w-1:0] data);
		@(posedge m_axi4_aclk);
		s_wb_adr_i <= adr;
		s_wb_we_i  <= 1'b0;
		s_wb_stb_i <= 1'b1;
		@(negedge m_axi4_aclk);
		check_value("s_wb_ack_o", {31'b0, s_wb_ack_o}, 32'd1);
		data = s_wb_dat_o;
		@(posedge m_axi4_aclk);
		s_wb_stb_i <= 1'b0;
	endtask

	task automatic model_write_reg(input logic [wb_adr_w-1:0] adr,
		input logic [wb_dat_w-1:0] data);
		case (adr)
			reg_autoflip:    model_autoflip = data[1:0];
			reg_addr0:       model_base[0] = data & addr_mask;
			reg_addr1:       model_base[1] = data & addr_mask;
			reg_addr2:       model_base[2] = data & addr_mask;
			reg_wparam_addr: model_wr_manual = data & addr_mask;
			reg_rparam_addr: model_rd_manual = data & addr_mask;
			default: ;
		endcase
	endtask

	// rotation: write start frees old write into new, read takes new,
	// write then takes the lowest buffer not in use
	task automatic model_start(input logic wr, input logic rd);
		logic [buf_w-1:0] old_write;
		logic [buf_w-1:0] cand;
		old_write = model_write;
		if (wr) begin
			model_new = old_write;
		end
		if (rd) begin
			model_read = model_new;
		end
		if (wr) begin
			cand = 2'd0;
			while (cand == model_read || cand == old_write) begin
				cand = cand + 2'd1;
			end
			model_write = cand;
		end
	endtask

	// ------------------------------
	// engine model
	// ------------------------------
	task automatic run_start(input logic [1:0] mask, input logic [buf_w-1:0] exp_new,
		input logic [buf_w-1:0] exp_write, input logic [buf_w-1:0] exp_read,
		input logic [addr_w-1:0] exp_wr_addr, input logic [addr_w-1:0] exp_rd_addr);
		logic [wb_dat_w-1:0] rdata;
		model_start(mask[0], mask[1]);
		check_pattern("buf_new", {30'b0, exp_new}, {30'b0, model_new});
		check_pattern("buf_write", {30'b0, exp_write}, {30'b0, model_write});
		check_pattern("buf_read", {30'b0, exp_read}, {30'b0, model_read});
		check_pattern("wr_addr_o", exp_wr_addr,
			model_addr(model_autoflip[0], model_write, model_wr_manual));
		check_pattern("rd_addr_o", exp_rd_addr,
			model_addr(model_autoflip[1], model_read, model_rd_manual));
		@(posedge m_axi4_aclk);
		wr_start_i <= mask[0];
		rd_start_i <= mask[1];
		if (mask[0]) begin
			wr_busy_i <= 1'b1;
		end
		if (mask[1]) begin
			rd_busy_i <= 1'b1;
		end
		// engine latches the address in the start cycle
		@(negedge m_axi4_aclk);
		check_value("wr_addr_o", wr_addr_o, exp_wr_addr);
		check_value("rd_addr_o", rd_addr_o, exp_rd_addr);
		@(posedge m_axi4_aclk);
		wr_start_i <= 1'b0;
		rd_start_i <= 1'b0;
		bus_read(reg_buf_new, rdata);
		check_value("buf_new", rdata, {30'b0, exp_new});
		bus_read(reg_buf_write, rdata);
		check_value("buf_write", rdata, {30'b0, exp_write});
		bus_read(reg_buf_read, rdata);
		check_value("buf_read", rdata, {30'b0, exp_read});
	endtask

	task automatic run_frame_end(input logic ch, input logic [wb_dat_w-1:0] exp_ctl);
		logic [wb_dat_w-1:0] rdata;
		logic                irq;
		string               chn;
		int                  k;
		if (ch) begin
			chn = "rd";
		end else begin
			chn = "wr";
		end
		@(posedge m_axi4_aclk);
		if (ch) begin
			rd_index_i <= rd_index_i + index_w'(1);
			rd_busy_i  <= 1'b0;
		end else begin
			wr_index_i <= wr_index_i + index_w'(1);
			wr_busy_i  <= 1'b0;
		end
		// pulse expected in the cycle after the third sampling edge
		for (k = 0; k < 5; k++) begin
			@(negedge m_axi4_aclk);
			irq = ch ? rd_irq_o : wr_irq_o;
			check_value($sformatf("%s_irq_o", chn), {31'b0, irq}, {31'b0, k == 3});
		end
		check_value($sformatf("%s_enable_o", chn),
			{31'b0, ch ? rd_enable_o : wr_enable_o}, {31'b0, exp_ctl[0]});
		check_value($sformatf("%s_update_o", chn),
			{31'b0, ch ? rd_update_o : wr_update_o}, {31'b0, exp_ctl[1]});
		bus_read(ch ? reg_rctl_control : reg_wctl_control, rdata);
		check_value($sformatf("%s control word", chn), rdata, exp_ctl);
	endtask

	// ------------------------------
	// main sequence
	// ------------------------------
	initial begin
		int                  fd;
		int                  code;
		int                  line_cnt;
		logic [7:0]          op;
		string               line;
		logic [31:0]         f1;
		logic [31:0]         f2;
		logic [31:0]         f3;
		logic [31:0]         f4;
		logic [31:0]         f5;
		logic [31:0]         f6;
		logic [wb_dat_w-1:0] data;
		logic [wb_dat_w-1:0] exp;

		$timeformat(-9, 0, " ns", 0);
		lcg_state       = 32'h34806f6c;
		last_rand       = '0;
		model_base[0]   = init_addr0;
		model_base[1]   = init_addr1;
		model_base[2]   = init_addr2;
		model_wr_manual = '0;
		model_rd_manual = '0;
		model_autoflip  = init_autoflip;
		model_new       = buf_none;
		model_write     = buf_none;
		model_read      = buf_none;

		s_wb_rst_i = 1'b1;
		s_wb_adr_i = '0;
		s_wb_dat_i = '0;
		s_wb_we_i  = 1'b0;
		s_wb_sel_i = '0;
		s_wb_stb_i = 1'b0;
		wr_start_i = 1'b0;
		wr_busy_i  = 1'b0;
		wr_index_i = '0;
		rd_start_i = 1'b0;
		rd_busy_i  = 1'b0;
		rd_index_i = '0;

		// line count sets the timeout
		line_cnt = 0;
		fd = $fopen(pattern_file, "r");
		if (fd == 0) begin
			err_cnt++;
			$display("pattern file %s could not be opened", pattern_file);
		end else begin
			while ($fgets(line, fd) != 0) begin
				line_cnt++;
			end
			$fclose(fd);
			fd = $fopen(pattern_file, "r");
		end
		cycle_limit = 16 * line_cnt + 100;

		repeat (2) @(posedge m_axi4_aclk);
		s_wb_rst_i <= 1'b0;
		@(negedge m_axi4_aclk);
		check_value("wr_irq_o", {31'b0, wr_irq_o}, 32'd0);
		check_value("rd_irq_o", {31'b0, rd_irq_o}, 32'd0);
		check_value("wr_enable_o", {31'b0, wr_enable_o}, 32'd0);
		check_value("rd_enable_o", {31'b0, rd_enable_o}, 32'd0);
		check_value("wr_update_o", {31'b0, wr_update_o}, 32'd0);
		check_value("rd_update_o", {31'b0, rd_update_o}, 32'd0);

		while (fd != 0 && $fscanf(fd, " %c", op) == 1) begin
			if (op == "#") begin
				code = $fgets(line, fd);
			end else if (op == "W") begin
				code = $fscanf(fd, "%h %h %h", f1, f2, f3);
				check_fields(code, 3, op);
				data = f2;
				if (f3[0]) begin
					lcg_state = lcg_next(lcg_state);
					last_rand = lcg_state;
					data      = last_rand;
				end
				model_write_reg(f1[wb_adr_w-1:0], data);
				bus_write(f1[wb_adr_w-1:0], data);
			end else if (op == "R") begin
				code = $fscanf(fd, "%h %h %h", f1, f2, f3);
				check_fields(code, 3, op);
				exp = f3[0] ? (last_rand & addr_mask) : f2;
				bus_read(f1[wb_adr_w-1:0], data);
				check_value($sformatf("s_wb_dat_o at %h", f1[wb_adr_w-1:0]), data, exp);
			end else if (op == "S") begin
				code = $fscanf(fd, "%h %h %h %h %h %h", f1, f2, f3, f4, f5, f6);
				check_fields(code, 6, op);
				run_start(f1[1:0], f2[buf_w-1:0], f3[buf_w-1:0], f4[buf_w-1:0], f5, f6);
			end else if (op == "F") begin
				code = $fscanf(fd, "%h %h", f1, f2);
				check_fields(code, 2, op);
				run_frame_end(f1[0], f2);
			end else begin
				err_cnt++;
				$display("unknown opcode %c in the pattern file", op);
				code = $fgets(line, fd);
			end
		end
		if (fd != 0) begin
			$fclose(fd);
		end

		repeat (2) @(posedge m_axi4_aclk);
		$display("%0d checks, %0d errors", check_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

// File: verilog/vdma_buf_if.sv
/* buffer configuration and selected frame addresses
   between register file and flip logic */
`timescale 1ns/1ps

interface vdma_buf_if
	import vdma_pkg::*;
	();

	// bit 0 write channel, bit 1 read channel
	logic [1:0]        autoflip;
	logic [addr_w-1:0] base0;
	logic [addr_w-1:0] base1;
	logic [addr_w-1:0] base2;
	logic [addr_w-1:0] wr_manual_addr;
	logic [addr_w-1:0] rd_manual_addr;

	logic [addr_w-1:0] wr_addr;
	logic [addr_w-1:0] rd_addr;
	logic [buf_w-1:0]  buf_new;
	logic [buf_w-1:0]  buf_write;
	logic [buf_w-1:0]  buf_read;

	modport regs (
		output autoflip, base0, base1, base2, wr_manual_addr, rd_manual_addr,
		input  buf_new, buf_write, buf_read
	);

	modport flip (
		input  autoflip, base0, base1, base2, wr_manual_addr, rd_manual_addr,
		output wr_addr, rd_addr, buf_new, buf_write, buf_read
	);

endinterface

// File: verilog/vdma_ctrl_top.sv
/* video DMA control block top level
   register file, buffer flip logic and frame-end detectors */
`timescale 1ns/1ps

module vdma_ctrl_top
	import vdma_pkg::*;
	(
	input  logic                m_axi4_aclk,
	input  logic                s_wb_rst_i,
	input  logic [wb_adr_w-1:0] s_wb_adr_i,
	input  logic [wb_dat_w-1:0] s_wb_dat_i,
	input  logic                s_wb_we_i,
	input  logic [wb_sel_w-1:0] s_wb_sel_i,
	input  logic                s_wb_stb_i,
	output logic [wb_dat_w-1:0] s_wb_dat_o,
	output logic                s_wb_ack_o,
	output logic                wr_irq_o,
	output logic                rd_irq_o,

	// write engine
	output logic                wr_enable_o,
	output logic                wr_update_o,
	output logic [addr_w-1:0]   wr_addr_o,
	input  logic                wr_start_i,
	input  logic                wr_busy_i,
	input  logic [index_w-1:0]  wr_index_i,

	// read engine
	output logic                rd_enable_o,
	output logic                rd_update_o,
	output logic [addr_w-1:0]   rd_addr_o,
	input  logic                rd_start_i,
	input  logic                rd_busy_i,
	input  logic [index_w-1:0]  rd_index_i
	);

	logic wr_done;
	logic rd_done;

	vdma_buf_if buf_if ();

	vdma_regs i_vdma_regs (
		.m_axi4_aclk (m_axi4_aclk),
		.s_wb_rst_i  (s_wb_rst_i),
		.s_wb_adr_i  (s_wb_adr_i),
		.s_wb_dat_i  (s_wb_dat_i),
		.s_wb_we_i   (s_wb_we_i),
		.s_wb_sel_i  (s_wb_sel_i),
		.s_wb_stb_i  (s_wb_stb_i),
		.s_wb_dat_o  (s_wb_dat_o),
		.s_wb_ack_o  (s_wb_ack_o),
		.buf_if      (buf_if.regs),
		.wr_done_i   (wr_done),
		.rd_done_i   (rd_done),
		.wr_busy_i   (wr_busy_i),
		.rd_busy_i   (rd_busy_i),
		.wr_index_i  (wr_index_i),
		.rd_index_i  (rd_index_i),
		.wr_enable_o (wr_enable_o),
		.wr_update_o (wr_update_o),
		.rd_enable_o (rd_enable_o),
		.rd_update_o (rd_update_o)
	);

	vdma_flip_ctrl i_vdma_flip_ctrl (
		.m_axi4_aclk (m_axi4_aclk),
		.s_wb_rst_i  (s_wb_rst_i),
		.wr_start_i  (wr_start_i),
		.rd_start_i  (rd_start_i),
		.buf_if      (buf_if.flip)
	);

	// ------------------------------
	// frame-end detectors
	// ------------------------------
	vdma_frame_done i_wr_done (
		.m_axi4_aclk (m_axi4_aclk),
		.s_wb_rst_i  (s_wb_rst_i),
		.index_i     (wr_index_i),
		.done_o      (wr_done),
		.irq_o       (wr_irq_o)
	);

	vdma_frame_done i_rd_done (
		.m_axi4_aclk (m_axi4_aclk),
		.s_wb_rst_i  (s_wb_rst_i),
		.index_i     (rd_index_i),
		.done_o      (rd_done),
		.irq_o       (rd_irq_o)
	);

	assign wr_addr_o = buf_if.wr_addr;
	assign rd_addr_o = buf_if.rd_addr;

endmodule

// File: verilog/vdma_flip_ctrl.sv
/* triple-buffer rotation and frame address selection */
`timescale 1ns/1ps

module vdma_flip_ctrl
	import vdma_pkg::*;
	(
	input  logic       m_axi4_aclk,
	input  logic       s_wb_rst_i,
	input  logic       wr_start_i,
	input  logic       rd_start_i,
	vdma_buf_if.flip   buf_if
	);

	logic [buf_w-1:0] buf_new_q;
	logic [buf_w-1:0] buf_write_q;
	logic [buf_w-1:0] buf_read_q;
	logic [buf_w-1:0] buf_new_d;
	logic [buf_w-1:0] buf_write_d;
	logic [buf_w-1:0] buf_read_d;

	// base of the buffer, manual address when flipping is off or nothing assigned
	function automatic logic [addr_w-1:0] pick_addr(
		input logic              flip_en,
		input logic [buf_w-1:0]  sel,
		input logic [addr_w-1:0] b0,
		input logic [addr_w-1:0] b1,
		input logic [addr_w-1:0] b2,
		input logic [addr_w-1:0] manual
	);
		if (!flip_en) begin
			return manual;
		end
		case (sel)
			2'd0:    return b0;
			2'd1:    return b1;
			2'd2:    return b2;
			default: return manual;
		endcase
	endfunction

	always_comb begin
		buf_new_d   = buf_new_q;
		buf_write_d = buf_write_q;
		buf_read_d  = buf_read_q;
		if (wr_start_i) begin
			buf_new_d = buf_write_q;
		end
		if (rd_start_i) begin
			buf_read_d = buf_new_d;
		end
		// counting down leaves the lowest free buffer
		if (wr_start_i) begin
			for (int i = 2; i >= 0; i--) begin
				if (buf_read_d != buf_w'(i) && buf_write_q != buf_w'(i)) begin
					buf_write_d = buf_w'(i);
				end
			end
		end
	end

	always_ff @(posedge m_axi4_aclk) begin
		if (s_wb_rst_i) begin
			buf_new_q   <= buf_none;
			buf_write_q <= buf_none;
			buf_read_q  <= buf_none;
		end else begin
			buf_new_q   <= buf_new_d;
			buf_write_q <= buf_write_d;
			buf_read_q  <= buf_read_d;
		end
	end

	// addresses follow the post-start state so the engine can latch them with start
	assign buf_if.wr_addr = pick_addr(buf_if.autoflip[0], buf_write_d, buf_if.base0,
		buf_if.base1, buf_if.base2, buf_if.wr_manual_addr);
	assign buf_if.rd_addr = pick_addr(buf_if.autoflip[1], buf_read_d, buf_if.base0,
		buf_if.base1, buf_if.base2, buf_if.rd_manual_addr);

	assign buf_if.buf_new   = buf_new_q;
	assign buf_if.buf_write = buf_write_q;
	assign buf_if.buf_read  = buf_read_q;

	// write and read never share a buffer, also after a read start alone
	a_no_shared_buf: assert property (@(posedge m_axi4_aclk) disable iff (s_wb_rst_i)
		(buf_write_q != buf_read_q) || (buf_write_q == buf_none)
			|| (buf_read_q == buf_none));

endmodule

// File: verilog/vdma_frame_done.sv
/* frame-end detector on index bit 0 with interrupt pulse */
`timescale 1ns/1ps

module vdma_frame_done
	import vdma_pkg::*;
	(
	input  logic               m_axi4_aclk,
	input  logic               s_wb_rst_i,
	input  logic [index_w-1:0] index_i,
	output logic               done_o,
	output logic               irq_o
	);

	// sample history of index bit 0
	logic [2:0] idx_sr;

	always_ff @(posedge m_axi4_aclk) begin
		if (s_wb_rst_i) begin
			idx_sr <= '0;
			irq_o  <= 1'b0;
		end else begin
			idx_sr <= {idx_sr[1:0], index_i[0]};
			irq_o  <= idx_sr[2] ^ idx_sr[1];
		end
	end

	// leads irq by one cycle so control bits clear on the edge irq rises
	assign done_o = idx_sr[2] ^ idx_sr[1];

	a_irq_single: assert property (@(posedge m_axi4_aclk) disable iff (s_wb_rst_i)
		irq_o |=> !irq_o);

endmodule

// File: verilog/vdma_pkg.sv
/* register map, widths and reset values of the video DMA control block
   plus the control word view shared by bus and channel logic */

package vdma_pkg;

	// ------------------------------
	// widths
	// ------------------------------
	localparam int addr_w   = 32;
	localparam int wb_adr_w = 8;
	localparam int wb_dat_w = 32;
	localparam int wb_sel_w = wb_dat_w / 8;
	localparam int index_w  = 8;
	localparam int buf_w    = 2;

	// buffer number 3 means no buffer assigned yet
	localparam logic [buf_w-1:0] buf_none = 2'd3;

	// ------------------------------
	// constants and reset values
	// ------------------------------
	localparam logic [addr_w-1:0]   addr_mask     = ~32'h0000_0003;
	localparam logic [wb_dat_w-1:0] ctl_mask      = 32'h0000_0007;
	localparam logic [wb_dat_w-1:0] core_id       = 32'h5644_4d41;
	localparam logic [wb_dat_w-1:0] core_version  = 32'h0001_0000;
	localparam logic [1:0]          init_autoflip = 2'b11;
	localparam logic [addr_w-1:0]   init_addr0    = 32'h0000_0000;
	localparam logic [addr_w-1:0]   init_addr1    = 32'h0010_0000;
	localparam logic [addr_w-1:0]   init_addr2    = 32'h0020_0000;

	// ------------------------------
	// word offsets
	// ------------------------------
	localparam logic [wb_adr_w-1:0] reg_id           = 8'h00;
	localparam logic [wb_adr_w-1:0] reg_version      = 8'h01;
	localparam logic [wb_adr_w-1:0] reg_autoflip     = 8'h04;
	localparam logic [wb_adr_w-1:0] reg_addr0        = 8'h08;
	localparam logic [wb_adr_w-1:0] reg_addr1        = 8'h09;
	localparam logic [wb_adr_w-1:0] reg_addr2        = 8'h0a;
	localparam logic [wb_adr_w-1:0] reg_buf_new      = 8'h0c;
	localparam logic [wb_adr_w-1:0] reg_buf_write    = 8'h0d;
	localparam logic [wb_adr_w-1:0] reg_buf_read     = 8'h0e;
	localparam logic [wb_adr_w-1:0] reg_wctl_control = 8'h44;
	localparam logic [wb_adr_w-1:0] reg_wctl_status  = 8'h45;
	localparam logic [wb_adr_w-1:0] reg_wctl_index   = 8'h47;
	localparam logic [wb_adr_w-1:0] reg_wparam_addr  = 8'h48;
	localparam logic [wb_adr_w-1:0] reg_rctl_control = 8'h84;
	localparam logic [wb_adr_w-1:0] reg_rctl_status  = 8'h85;
	localparam logic [wb_adr_w-1:0] reg_rctl_index   = 8'h87;
	localparam logic [wb_adr_w-1:0] reg_rparam_addr  = 8'h88;

	// control word, enable in bit 0
	typedef struct packed {
		logic [28:0] rsvd;
		logic        oneshot;
		logic        update;
		logic        enable;
	} ctl_fields_t;

	typedef union packed {
		logic [wb_dat_w-1:0] raw;
		ctl_fields_t         fields;
	} ctl_word_u;

endpackage

// File: verilog/vdma_regs.sv
/* wishbone register file with byte lanes, read mux
   and frame-end updates of the channel control words */
`timescale 1ns/1ps

module vdma_regs
	import vdma_pkg::*;
	(
	input  logic                m_axi4_aclk,
	input  logic                s_wb_rst_i,
	input  logic [wb_adr_w-1:0] s_wb_adr_i,
	input  logic [wb_dat_w-1:0] s_wb_dat_i,
	input  logic                s_wb_we_i,
	input  logic [wb_sel_w-1:0] s_wb_sel_i,
	input  logic                s_wb_stb_i,
	output logic [wb_dat_w-1:0] s_wb_dat_o,
	output logic                s_wb_ack_o,
	vdma_buf_if.regs            buf_if,
	input  logic                wr_done_i,
	input  logic                rd_done_i,
	input  logic                wr_busy_i,
	input  logic                rd_busy_i,
	input  logic [index_w-1:0]  wr_index_i,
	input  logic [index_w-1:0]  rd_index_i,
	output logic                wr_enable_o,
	output logic                wr_update_o,
	output logic                rd_enable_o,
	output logic                rd_update_o
	);

	logic [1:0]          ctl_autoflip;
	logic [addr_w-1:0]   param_addr0;
	logic [addr_w-1:0]   param_addr1;
	logic [addr_w-1:0]   param_addr2;
	logic [addr_w-1:0]   wparam_addr;
	logic [addr_w-1:0]   rparam_addr;
	ctl_word_u           wctl_control;
	ctl_word_u           rctl_control;
	logic [wb_dat_w-1:0] wb_bmask;
	logic                wb_wr;

	// merge the written bytes into the current value
	function automatic logic [wb_dat_w-1:0] lane_merge(
		input logic [wb_dat_w-1:0] cur,
		input logic [wb_dat_w-1:0] wdat,
		input logic [wb_dat_w-1:0] mask
	);
		return (cur & ~mask) | (wdat & mask);
	endfunction

	always_comb begin
		for (int b = 0; b < wb_sel_w; b++) begin
			wb_bmask[8*b +: 8] = {8{s_wb_sel_i[b]}};
		end
	end

	assign wb_wr = s_wb_stb_i & s_wb_we_i;

	// ------------------------------
	// register write
	// ------------------------------
	always_ff @(posedge m_axi4_aclk) begin
		if (s_wb_rst_i) begin
			ctl_autoflip     <= init_autoflip;
			param_addr0      <= init_addr0;
			param_addr1      <= init_addr1;
			param_addr2      <= init_addr2;
			wparam_addr      <= '0;
			rparam_addr      <= '0;
			wctl_control.raw <= '0;
			rctl_control.raw <= '0;
		end else begin
			if (wb_wr) begin
				case (s_wb_adr_i)
					reg_autoflip:
						ctl_autoflip <= (ctl_autoflip & ~wb_bmask[1:0])
							| (s_wb_dat_i[1:0] & wb_bmask[1:0]);
					reg_addr0:
						param_addr0 <= lane_merge(param_addr0, s_wb_dat_i, wb_bmask) & addr_mask;
					reg_addr1:
						param_addr1 <= lane_merge(param_addr1, s_wb_dat_i, wb_bmask) & addr_mask;
					reg_addr2:
						param_addr2 <= lane_merge(param_addr2, s_wb_dat_i, wb_bmask) & addr_mask;
					reg_wparam_addr:
						wparam_addr <= lane_merge(wparam_addr, s_wb_dat_i, wb_bmask) & addr_mask;
					reg_rparam_addr:
						rparam_addr <= lane_merge(rparam_addr, s_wb_dat_i, wb_bmask) & addr_mask;
					reg_wctl_control:
						wctl_control.raw <= lane_merge(wctl_control.raw, s_wb_dat_i, wb_bmask)
							& ctl_mask;
					reg_rctl_control:
						rctl_control.raw <= lane_merge(rctl_control.raw, s_wb_dat_i, wb_bmask)
							& ctl_mask;
					default: ;
				endcase
			end

			// frame end, takes priority over a bus write in the same cycle
			if (wr_done_i) begin
				if (!ctl_autoflip[0]) begin
					wctl_control.fields.update <= 1'b0;
				end
				if (wctl_control.fields.oneshot) begin
					wctl_control.fields.enable  <= 1'b0;
					wctl_control.fields.oneshot <= 1'b0;
				end
			end
			if (rd_done_i) begin
				if (!ctl_autoflip[1]) begin
					rctl_control.fields.update <= 1'b0;
				end
				if (rctl_control.fields.oneshot) begin
					rctl_control.fields.enable  <= 1'b0;
					rctl_control.fields.oneshot <= 1'b0;
				end
			end
		end
	end

	// ------------------------------
	// read mux
	// ------------------------------
	always_comb begin
		case (s_wb_adr_i)
			reg_id:           s_wb_dat_o = core_id;
			reg_version:      s_wb_dat_o = core_version;
			reg_autoflip:     s_wb_dat_o = {{(wb_dat_w-2){1'b0}}, ctl_autoflip};
			reg_addr0:        s_wb_dat_o = param_addr0;
			reg_addr1:        s_wb_dat_o = param_addr1;
			reg_addr2:        s_wb_dat_o = param_addr2;
			reg_buf_new:      s_wb_dat_o = {{(wb_dat_w-buf_w){1'b0}}, buf_if.buf_new};
			reg_buf_write:    s_wb_dat_o = {{(wb_dat_w-buf_w){1'b0}}, buf_if.buf_write};
			reg_buf_read:     s_wb_dat_o = {{(wb_dat_w-buf_w){1'b0}}, buf_if.buf_read};
			reg_wctl_control: s_wb_dat_o = wctl_control.raw;
			reg_wctl_status:  s_wb_dat_o = {{(wb_dat_w-1){1'b0}}, wr_busy_i};
			reg_wctl_index:   s_wb_dat_o = {{(wb_dat_w-index_w){1'b0}}, wr_index_i};
			reg_wparam_addr:  s_wb_dat_o = wparam_addr;
			reg_rctl_control: s_wb_dat_o = rctl_control.raw;
			reg_rctl_status:  s_wb_dat_o = {{(wb_dat_w-1){1'b0}}, rd_busy_i};
			reg_rctl_index:   s_wb_dat_o = {{(wb_dat_w-index_w){1'b0}}, rd_index_i};
			reg_rparam_addr:  s_wb_dat_o = rparam_addr;
			default:          s_wb_dat_o = '0;
		endcase
	end

	assign s_wb_ack_o = s_wb_stb_i;

	assign buf_if.autoflip       = ctl_autoflip;
	assign buf_if.base0          = param_addr0;
	assign buf_if.base1          = param_addr1;
	assign buf_if.base2          = param_addr2;
	assign buf_if.wr_manual_addr = wparam_addr;
	assign buf_if.rd_manual_addr = rparam_addr;

	assign wr_enable_o = wctl_control.fields.enable;
	assign wr_update_o = wctl_control.fields.update;
	assign rd_enable_o = rctl_control.fields.enable;
	assign rd_update_o = rctl_control.fields.update;

	// a one-shot channel stops at frame end even with a bus write pending
	a_wr_oneshot_stop: assert property (@(posedge m_axi4_aclk) disable iff (s_wb_rst_i)
		wr_done_i && wctl_control.fields.oneshot |=> !wctl_control.fields.enable);
	a_rd_oneshot_stop: assert property (@(posedge m_axi4_aclk) disable iff (s_wb_rst_i)
		rd_done_i && rctl_control.fields.oneshot |=> !rctl_control.fields.enable);

endmodule
